/* files.f */
source/rvfi_chk_pkg.sv
source/rvfi_chk_ctrl.sv
source/rvfi_trap_rules.sv
source/rvfi_ack_rules.sv
source/rvfi_viol_log.sv
source/rvfi_chk_axil.sv
source/rvfi_chk_top.sv
dv/rvfi_chk_props.sv
dv/rvfi_chk_tb.sv

/* Makefile */
# Verilator build and run of the retirement-trace checker testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module rvfi_chk_tb -o sim_rvfi_chk
	./obj_dir/sim_rvfi_chk > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "test did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* dv/rvfi_chk_vectors.txt */
# gap intr exc dbg cause dbg_cause rvfi_dbg mcause step pc debug_mode irq_ack dbg_ack expected
# All hex, acks pulse in the first gap cycle, debug_mode covers the gap and the retirement
2 0 0 0 00 0 0 00 0 00001000 0 0 0 00
1 0 1 0 0b 0 0 00 0 00001004 0 0 0 00
2 1 0 0 00 0 0 0b 0 00001100 0 0 0 00
1 0 1 0 02 0 0 00 0 00001104 0 0 0 00
1 0 0 0 00 0 0 05 0 00001108 0 0 0 03
1 0 1 0 03 0 0 00 0 0000110c 0 0 0 00
2 0 0 0 00 0 0 07 0 00001110 1 0 0 00
1 0 0 1 00 3 0 00 0 00001114 0 0 0 00
2 0 0 0 00 0 3 00 0 00000800 1 0 1 00
1 0 0 1 00 2 0 00 0 00000804 0 0 0 00
1 0 0 0 00 0 1 00 0 00000808 1 0 0 24
1 0 1 1 03 1 0 00 0 00001200 0 0 0 08
1 1 0 0 00 0 1 03 0 00001204 0 0 1 00
2 0 0 0 00 0 0 00 0 00001300 0 1 0 10
1 1 0 0 00 0 0 00 0 00001304 0 1 0 00
1 0 1 1 00 4 0 00 1 00001308 0 0 0 00
1 0 0 0 00 0 2 09 0 00000900 1 0 1 04
1 0 0 0 00 0 4 00 0 00000904 1 0 0 20
3 0 0 0 00 0 0 00 0 00001400 0 0 0 00

/* dv/rvfi_chk_tb.sv */
// Replays retirement vectors twice, unmasked and then with MCAUSE and DBG_ACK masked
// Each vector needs a gap of at least one cycle when it carries an acknowledge

`timescale 1ns/1ns

module rvfi_chk_tb import rvfi_chk_pkg::*; ();

  localparam int MAX_VEC = 64;

  logic clk_i, rst_ni;
  logic rvfi_valid_i, rvfi_intr_i, rvfi_trap_exc_i, rvfi_trap_dbg_i, rvfi_dcsr_step_i;
  exc_cause_t rvfi_trap_cause_i, rvfi_mcause_i;
  dbg_cause_t rvfi_trap_dbg_cause_i, rvfi_dbg_i;
  pc_t  rvfi_pc_i;
  logic debug_mode_i, irq_ack_i, dbg_ack_i;
  logic awvalid, wvalid, bready, arvalid, rready;
  axil_addr_t awaddr, araddr;
  axil_data_t wdata, rdata;
  logic awready, wready, bvalid, arready, rvalid, irq_o;
  logic [1:0] bresp, rresp;

  // Vector table, one entry per file line
  logic [31:0] v_gap [MAX_VEC], v_intr [MAX_VEC], v_exc [MAX_VEC], v_dbg [MAX_VEC];
  logic [31:0] v_cause [MAX_VEC], v_dcause [MAX_VEC], v_rdbg [MAX_VEC];
  logic [31:0] v_mcause [MAX_VEC], v_step [MAX_VEC], v_pc [MAX_VEC], v_dmode [MAX_VEC];
  logic [31:0] v_iack [MAX_VEC], v_dack [MAX_VEC], v_exp [MAX_VEC];
  int num_vec;
  int cycle_cnt;
  int cycle_limit;
  int error_count;
  logic [15:0] lfsr;

  // Reference model of the log registers
  rule_vec_t model_status;
  viol_cnt_t model_count;
  pc_t       model_pc;

  rvfi_chk_top dut_i (
    .clk_i, .rst_ni, .rvfi_valid_i, .rvfi_intr_i, .rvfi_trap_exc_i, .rvfi_trap_dbg_i,
    .rvfi_trap_cause_i, .rvfi_trap_dbg_cause_i, .rvfi_dbg_i, .rvfi_mcause_i,
    .rvfi_dcsr_step_i, .rvfi_pc_i, .debug_mode_i, .irq_ack_i, .dbg_ack_i,
    .s_axil_awvalid_i(awvalid), .s_axil_awaddr_i(awaddr), .s_axil_wvalid_i(wvalid),
    .s_axil_wdata_i(wdata), .s_axil_bready_i(bready), .s_axil_arvalid_i(arvalid),
    .s_axil_araddr_i(araddr), .s_axil_rready_i(rready), .s_axil_awready_o(awready),
    .s_axil_wready_o(wready), .s_axil_bvalid_o(bvalid), .s_axil_bresp_o(bresp),
    .s_axil_arready_o(arready), .s_axil_rvalid_o(rvalid), .s_axil_rdata_o(rdata),
    .s_axil_rresp_o(rresp), .irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = !clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_status(input rule_vec_t got, input rule_vec_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: status got %h expected %h", $time, got, exp));
  endtask

  task automatic check_count(input viol_cnt_t got, input viol_cnt_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: count got %h expected %h", $time, got, exp));
  endtask

  task automatic check_pc(input pc_t got, input pc_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: first_pc got %h expected %h", $time, got, exp));
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: irq_o got %b expected %b", $time, got, exp));
  endtask

  task automatic check_data(input axil_data_t got, input axil_data_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: rdata got %h expected %h", $time, got, exp));
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  // Cycle limit, set once the vector file has been read
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
      report_failure($sformatf("timeout after %0d cycles waiting for the DUT", cycle_cnt));
  end

  // Galois LFSR, one step per random bit
  task automatic random_stall(output int n);
    int i;
    n = 0;
    for (i = 0; i < 2; i++) begin
      n = (n << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////////////////////////

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    @(posedge clk_i);
    #1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    bready  = 1'b1;
    while (!(awready && wready)) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(posedge clk_i);
      #1;
    end
    // Every write is answered with OKAY
    check_resp("bresp", bresp, 2'b00);
    @(posedge clk_i);
    #1;
  endtask

  task automatic axil_read(input axil_addr_t addr, input int stall, output axil_data_t data);
    @(posedge clk_i);
    #1;
    arvalid = 1'b1;
    araddr  = addr;
    rready  = 1'b0;
    while (!arready) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge clk_i);
      #1;
    end
    repeat (stall) begin
      @(posedge clk_i);
      #1;
    end
    data   = rdata;
    // Mapped and unmapped offsets alike answer with OKAY
    check_resp("rresp", rresp, 2'b00);
    rready = 1'b1;
    @(posedge clk_i);
    #1;
    rready = 1'b0;
  endtask

  task automatic read_stalled(input axil_addr_t addr, output axil_data_t data);
    int n;
    random_stall(n);
    axil_read(addr, n, data);
  endtask

  ////////////////////////////////////////////////////////////
  // Vector replay
  ////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    fd = $fopen("dv/rvfi_chk_vectors.txt", "r");
    if (fd == 0)
      report_failure("could not open the vector file dv/rvfi_chk_vectors.txt");
    num_vec = 0;
    while (!$feof(fd) && num_vec < MAX_VEC) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v_gap[num_vec], v_intr[num_vec], v_exc[num_vec], v_dbg[num_vec],
                    v_cause[num_vec], v_dcause[num_vec], v_rdbg[num_vec],
                    v_mcause[num_vec], v_step[num_vec], v_pc[num_vec], v_dmode[num_vec],
                    v_iack[num_vec], v_dack[num_vec], v_exp[num_vec]);
        if (n == 14)
          num_vec++;
      end
    end
    $fclose(fd);
    if (num_vec == 0)
      report_failure("the vector file holds no vectors");
  endtask

  task automatic apply_vector(input int i);
    int g;
    for (g = 0; g < int'(v_gap[i]); g++) begin
      @(posedge clk_i);
      #1;
      debug_mode_i = v_dmode[i][0];
      irq_ack_i    = (g == 0) ? v_iack[i][0] : 1'b0;
      dbg_ack_i    = (g == 0) ? v_dack[i][0] : 1'b0;
    end
    @(posedge clk_i);
    #1;
    irq_ack_i             = 1'b0;
    dbg_ack_i             = 1'b0;
    debug_mode_i          = v_dmode[i][0];
    rvfi_valid_i          = 1'b1;
    rvfi_intr_i           = v_intr[i][0];
    rvfi_trap_exc_i       = v_exc[i][0];
    rvfi_trap_dbg_i       = v_dbg[i][0];
    rvfi_trap_cause_i     = v_cause[i][5:0];
    rvfi_trap_dbg_cause_i = v_dcause[i][2:0];
    rvfi_dbg_i            = v_rdbg[i][2:0];
    rvfi_mcause_i         = v_mcause[i][5:0];
    rvfi_dcsr_step_i      = v_step[i][0];
    rvfi_pc_i             = v_pc[i];
    @(posedge clk_i);
    #1;
    clear_trace();
  endtask

  task automatic clear_trace();
    rvfi_valid_i = 1'b0;
    rvfi_intr_i = 1'b0;
    rvfi_trap_exc_i = 1'b0;
    rvfi_trap_dbg_i = 1'b0;
    rvfi_trap_cause_i = '0;
    rvfi_trap_dbg_cause_i = '0;
    rvfi_dbg_i = '0;
    rvfi_mcause_i = '0;
    rvfi_dcsr_step_i = 1'b0;
    rvfi_pc_i = '0;
    debug_mode_i = 1'b0;
    irq_ack_i = 1'b0;
    dbg_ack_i = 1'b0;
  endtask

  task automatic run_vectors(input rule_vec_t mask);
    int i;
    rule_vec_t hit;
    axil_data_t data;
    for (i = 0; i < num_vec; i++) begin
      apply_vector(i);
      // Masked rules neither set status nor count
      hit = v_exp[i][NUM_RULES-1:0] & ~mask;
      model_status = model_status | hit;
      if (hit != '0) begin
        if (model_count == '0)
          model_pc = v_pc[i];
        model_count = model_count + 16'd1;
      end
      read_stalled(REG_STATUS, data);
      check_status(data[NUM_RULES-1:0], model_status);
      check_irq(irq_o, |model_status);
      read_stalled(REG_COUNT, data);
      check_count(data[15:0], model_count);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int i;
    int gap_sum;
    axil_data_t data;
    axil_data_t data_stalled;
    axil_data_t exp_data;
    axil_addr_t addr;
    rst_ni = 1'b0;
    clear_trace();
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    rready = 1'b0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    cycle_cnt = 0;
    cycle_limit = 0;
    error_count = 0;
    lfsr = 16'd38;
    model_status = '0;
    model_count = '0;
    model_pc = '0;

    load_vectors();
    gap_sum = 0;
    for (i = 0; i < num_vec; i++)
      gap_sum += int'(v_gap[i]);
    // Both passes replay every vector
    cycle_limit = 2 * (gap_sum + 20 * num_vec) + 200;

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Reset values
    check_irq(irq_o, 1'b0);
    for (i = 0; i < 4; i++) begin
      axil_read(axil_addr_t'(4 * i), 0, data);
      check_data(data, '0);
    end

    // Unmasked pass
    axil_write(REG_CTRL, 32'h1);
    axil_read(REG_CTRL, 0, data);
    check_data(data, 32'h1);
    run_vectors('0);
    axil_read(REG_FIRST_PC, 0, data);
    check_pc(data, model_pc);

    // An unmapped offset reads zero even while status bits are set
    axil_read(4'h6, 0, data);
    check_data(data, '0);

    // Write-one-to-clear, partial and then complete
    axil_write(REG_STATUS, 32'h05);
    model_status = model_status & ~rule_vec_t'(6'h05);
    axil_read(REG_STATUS, 0, data);
    check_status(data[NUM_RULES-1:0], model_status);
    check_irq(irq_o, |model_status);
    axil_write(REG_STATUS, 32'h3f);
    model_status = '0;
    axil_read(REG_STATUS, 0, data);
    check_status(data[NUM_RULES-1:0], model_status);
    check_irq(irq_o, 1'b0);
    axil_read(REG_COUNT, 0, data);
    check_count(data[15:0], model_count);

    // Masked pass with MCAUSE and DBG_ACK disabled, from a fresh context
    axil_write(REG_CTRL, 32'h0);
    axil_write(REG_CTRL, 32'h2201);
    axil_read(REG_CTRL, 0, data);
    check_data(data, 32'h2201);
    run_vectors(rule_vec_t'(6'h22));
    axil_read(REG_FIRST_PC, 0, data);
    check_pc(data, model_pc);

    // Stalled and unstalled reads both return the modelled register value
    for (i = 0; i < 5; i++) begin
      addr = axil_addr_t'(4 * (i % 4));
      case (addr)
        REG_CTRL:   exp_data = 32'h2201;
        REG_STATUS: exp_data = axil_data_t'(model_status);
        REG_COUNT:  exp_data = axil_data_t'(model_count);
        default:    exp_data = model_pc;
      endcase
      axil_read(addr, 0, data);
      check_data(data, exp_data);
      read_stalled(addr, data_stalled);
      check_data(data_stalled, exp_data);
    end

    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* dv/rvfi_chk_props.sv */
// Bound into the checker top level so that the internal status vector is visible
// All properties are disabled while reset is low

`timescale 1ns/1ns

module rvfi_chk_props import rvfi_chk_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       bvalid_i,
  input logic       bready_i,
  input logic       rvalid_i,
  input logic       rready_i,
  input axil_data_t rdata_i,
  input rule_vec_t  status_i,
  input logic       irq_i
);

  // A write response stays up until the master takes it
  bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  // Read data stays valid and unchanged while the master stalls
  rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("rvalid or rdata changed during a stall");

  // The interrupt is the OR of the sticky status bits
  irq_is_status: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_i == (|status_i))
    else $error("irq_o differs from the OR of status");

endmodule

bind rvfi_chk_top rvfi_chk_props u_props (
  .clk_i, .rst_ni, .bvalid_i(s_axil_bvalid_o), .bready_i(s_axil_bready_i),
  .rvalid_i(s_axil_rvalid_o), .rready_i(s_axil_rready_i), .rdata_i(s_axil_rdata_o),
  .status_i(status), .irq_i(irq_o)
);

/* source/rvfi_chk_top.sv */
// Retirement-trace checker with an AXI4-Lite register port
// The trace is never back-pressured, one retirement per cycle at most

`timescale 1ns/1ns

module rvfi_chk_top import rvfi_chk_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Retirement trace
  input  logic       rvfi_valid_i,
  input  logic       rvfi_intr_i,
  input  logic       rvfi_trap_exc_i,
  input  logic       rvfi_trap_dbg_i,
  input  exc_cause_t rvfi_trap_cause_i,
  input  dbg_cause_t rvfi_trap_dbg_cause_i,
  input  dbg_cause_t rvfi_dbg_i,
  input  exc_cause_t rvfi_mcause_i,
  input  logic       rvfi_dcsr_step_i,
  input  pc_t        rvfi_pc_i,
  // Core state sampled every cycle
  input  logic       debug_mode_i,
  input  logic       irq_ack_i,
  input  logic       dbg_ack_i,
  // Register port
  input  logic       s_axil_awvalid_i,
  input  axil_addr_t s_axil_awaddr_i,
  input  logic       s_axil_wvalid_i,
  input  axil_data_t s_axil_wdata_i,
  input  logic       s_axil_bready_i,
  input  logic       s_axil_arvalid_i,
  input  axil_addr_t s_axil_araddr_i,
  input  logic       s_axil_rready_i,
  output logic       s_axil_awready_o,
  output logic       s_axil_wready_o,
  output logic       s_axil_bvalid_o,
  output logic [1:0] s_axil_bresp_o,
  output logic       s_axil_arready_o,
  output logic       s_axil_rvalid_o,
  output axil_data_t s_axil_rdata_o,
  output logic [1:0] s_axil_rresp_o,
  output logic       irq_o
);

  logic       retire, clear, follow, prev_clean, prev_exc, prev_dbg;
  exc_cause_t prev_cause;
  dbg_cause_t prev_dbg_cause;
  trap_viol_t trap_viol;
  ack_viol_t  ack_viol;
  rule_vec_t  status, rule_mask, status_clr;
  viol_cnt_t  count;
  pc_t        first_pc;
  logic       ctrl_en;

  rvfi_chk_ctrl u_ctrl (
    .clk_i, .rst_ni, .ctrl_en_i(ctrl_en), .rvfi_valid_i, .rvfi_trap_exc_i,
    .rvfi_trap_dbg_i, .rvfi_trap_cause_i, .rvfi_trap_dbg_cause_i, .debug_mode_i,
    .rvfi_dcsr_step_i, .retire_o(retire), .clear_o(clear), .follow_o(follow),
    .prev_clean_o(prev_clean), .prev_exc_o(prev_exc), .prev_dbg_o(prev_dbg),
    .prev_cause_o(prev_cause), .prev_dbg_cause_o(prev_dbg_cause)
  );

  rvfi_trap_rules u_trap_rules (
    .retire_i(retire), .follow_i(follow), .prev_clean_i(prev_clean),
    .prev_exc_i(prev_exc), .prev_dbg_i(prev_dbg), .prev_cause_i(prev_cause),
    .prev_dbg_cause_i(prev_dbg_cause), .rvfi_intr_i, .rvfi_trap_exc_i, .rvfi_trap_dbg_i,
    .rvfi_trap_dbg_cause_i, .rvfi_dbg_i, .rvfi_mcause_i, .trap_viol_o(trap_viol)
  );

  rvfi_ack_rules u_ack_rules (
    .clk_i, .rst_ni, .retire_i(retire), .clear_i(clear), .rvfi_intr_i, .rvfi_dbg_i,
    .irq_ack_i, .dbg_ack_i, .ack_viol_o(ack_viol)
  );

  rvfi_viol_log u_viol_log (
    .clk_i, .rst_ni, .retire_i(retire), .rvfi_pc_i, .trap_viol_i(trap_viol),
    .ack_viol_i(ack_viol), .rule_mask_i(rule_mask), .status_clr_i(status_clr),
    .status_o(status), .count_o(count), .first_pc_o(first_pc), .irq_o
  );

  rvfi_chk_axil u_axil (
    .clk_i, .rst_ni, .s_axil_awvalid_i, .s_axil_awaddr_i, .s_axil_wvalid_i,
    .s_axil_wdata_i, .s_axil_bready_i, .s_axil_arvalid_i, .s_axil_araddr_i,
    .s_axil_rready_i, .status_i(status), .count_i(count), .first_pc_i(first_pc),
    .s_axil_awready_o, .s_axil_wready_o, .s_axil_bvalid_o, .s_axil_bresp_o,
    .s_axil_arready_o, .s_axil_rvalid_o, .s_axil_rdata_o, .s_axil_rresp_o,
    .ctrl_en_o(ctrl_en), .rule_mask_o(rule_mask), .status_clr_o(status_clr)
  );

endmodule

/* source/rvfi_chk_axil.sv */
// AXI4-Lite slave with one outstanding write and one outstanding read
// Write strobes are not supported, every write updates the whole register

`timescale 1ns/1ns

module rvfi_chk_axil import rvfi_chk_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       s_axil_awvalid_i,
  input  axil_addr_t s_axil_awaddr_i,
  input  logic       s_axil_wvalid_i,
  input  axil_data_t s_axil_wdata_i,
  input  logic       s_axil_bready_i,
  input  logic       s_axil_arvalid_i,
  input  axil_addr_t s_axil_araddr_i,
  input  logic       s_axil_rready_i,
  input  rule_vec_t  status_i,
  input  viol_cnt_t  count_i,
  input  pc_t        first_pc_i,
  output logic       s_axil_awready_o,
  output logic       s_axil_wready_o,
  output logic       s_axil_bvalid_o,
  output logic [1:0] s_axil_bresp_o,
  output logic       s_axil_arready_o,
  output logic       s_axil_rvalid_o,
  output axil_data_t s_axil_rdata_o,
  output logic [1:0] s_axil_rresp_o,
  output logic       ctrl_en_o,
  output rule_vec_t  rule_mask_o,
  output rule_vec_t  status_clr_o
);

  logic       wr_ready_q;
  logic       wr_accept;
  logic       rd_accept;
  axil_data_t rd_mux;

  ////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////

  // Address and data are accepted together in the cycle the ready pulse is high
  assign wr_accept        = wr_ready_q && s_axil_awvalid_i && s_axil_wvalid_i;
  assign s_axil_awready_o = wr_ready_q;
  assign s_axil_wready_o  = wr_ready_q;
  assign s_axil_bresp_o   = AXIL_RESP_OKAY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ready_q      <= 1'b0;
      s_axil_bvalid_o <= 1'b0;
      ctrl_en_o       <= 1'b0;
      rule_mask_o     <= '0;
      status_clr_o    <= '0;
    end else begin
      // Ready only pulses while no response is waiting
      wr_ready_q   <= s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o && !wr_ready_q;
      status_clr_o <= '0;
      if (wr_accept) begin
        s_axil_bvalid_o <= 1'b1;
      end else if (s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
      if (wr_accept && (s_axil_awaddr_i == REG_CTRL)) begin
        ctrl_en_o   <= s_axil_wdata_i[CTRL_EN_BIT];
        rule_mask_o <= s_axil_wdata_i[CTRL_MASK_LSB +: NUM_RULES];
      end
      // Writing ones to STATUS clears those bits for one cycle
      if (wr_accept && (s_axil_awaddr_i == REG_STATUS)) begin
        status_clr_o <= s_axil_wdata_i[NUM_RULES-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////////////

  assign s_axil_arready_o = !s_axil_rvalid_o;
  assign rd_accept        = s_axil_arvalid_i && s_axil_arready_o;
  assign s_axil_rresp_o   = AXIL_RESP_OKAY;

  // Unmapped offsets read as zero
  always_comb begin
    rd_mux = '0;
    case (s_axil_araddr_i)
      REG_CTRL: begin
        rd_mux[CTRL_EN_BIT]                 = ctrl_en_o;
        rd_mux[CTRL_MASK_LSB +: NUM_RULES]  = rule_mask_o;
      end
      REG_STATUS:   rd_mux[NUM_RULES-1:0] = status_i;
      REG_COUNT:    rd_mux[15:0]          = count_i;
      REG_FIRST_PC: rd_mux                = first_pc_i;
      default:      rd_mux                = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s_axil_rvalid_o <= 1'b0;
    end else if (rd_accept) begin
      s_axil_rvalid_o <= 1'b1;
    end else if (s_axil_rready_i) begin
      s_axil_rvalid_o <= 1'b0;
    end
  end

  // Read data is captured once and held while the master stalls
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      s_axil_rdata_o <= rd_mux;
    end
  end

endmodule

/* source/rvfi_viol_log.sv */
// Status bits are sticky until cleared through the register port
// A set in the same cycle as its clear wins, so no violation is lost

`timescale 1ns/1ns

module rvfi_viol_log import rvfi_chk_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       retire_i,
  input  pc_t        rvfi_pc_i,
  input  trap_viol_t trap_viol_i,
  input  ack_viol_t  ack_viol_i,
  input  rule_vec_t  rule_mask_i,
  input  rule_vec_t  status_clr_i,
  output rule_vec_t  status_o,
  output viol_cnt_t  count_o,
  output pc_t        first_pc_o,
  output logic       irq_o
);

  rule_vec_t viol_raw;
  rule_vec_t viol_masked;
  logic      viol_hit;

  // Trap rules take the low bits, acknowledge rules the top two
  assign viol_raw = {ack_viol_i, trap_viol_i};

  // A set mask bit disables its rule entirely
  assign viol_masked = retire_i ? (viol_raw & ~rule_mask_i) : '0;
  assign viol_hit    = |viol_masked;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_o   <= '0;
      count_o    <= '0;
      first_pc_o <= '0;
    end else begin
      status_o <= (status_o & ~status_clr_i) | viol_masked;
      // One count per violating retirement, however many rules it breaks
      if (viol_hit && (count_o != '1)) begin
        count_o <= count_o + 16'd1;
      end
      // Only the first violation since reset is located
      if (viol_hit && (count_o == '0)) begin
        first_pc_o <= rvfi_pc_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Interrupt
  ////////////////////////////////////////////////////////////

  // Level interrupt while any status bit is pending
  assign irq_o = |status_o;

endmodule

/* source/rvfi_ack_rules.sv */
// Acknowledges are sampled every cycle, including cycles without a retirement
// The debug acknowledge count saturates at 3, deeper nesting is not tracked

`timescale 1ns/1ns

module rvfi_ack_rules import rvfi_chk_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       retire_i,
  input  logic       clear_i,
  input  logic       rvfi_intr_i,
  input  dbg_cause_t rvfi_dbg_i,
  input  logic       irq_ack_i,
  input  logic       dbg_ack_i,
  output ack_viol_t  ack_viol_o
);

  localparam ack_cnt_t ACK_CNT_MAX = 2'd3;

  logic     irq_pend_q;
  ack_cnt_t dbg_cnt_q;
  logic     dbg_retire;

  // A retirement that reports a debug entry consumes one acknowledge
  assign dbg_retire = retire_i && (rvfi_dbg_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_pend_q <= 1'b0;
      dbg_cnt_q  <= '0;
    end else if (clear_i) begin
      irq_pend_q <= 1'b0;
      dbg_cnt_q  <= '0;
    end else begin
      // An acknowledge together with a retirement waits for the next one
      if (retire_i) begin
        irq_pend_q <= irq_ack_i;
      end else if (irq_ack_i) begin
        irq_pend_q <= 1'b1;
      end
      // Simultaneous acknowledge and debug entry leave the count unchanged
      if (dbg_ack_i && !dbg_retire && (dbg_cnt_q != ACK_CNT_MAX)) begin
        dbg_cnt_q <= dbg_cnt_q + 2'd1;
      end else if (dbg_retire && !dbg_ack_i && (dbg_cnt_q != '0)) begin
        dbg_cnt_q <= dbg_cnt_q - 2'd1;
      end
    end
  end

  always_comb begin
    ack_viol_o = '0;
    ack_viol_o[RULE_IRQ_ACK - RULE_IRQ_ACK] = retire_i && irq_pend_q && !rvfi_intr_i;
    ack_viol_o[RULE_DBG_ACK - RULE_IRQ_ACK] = dbg_retire && (dbg_cnt_q == '0);
  end

endmodule

/* source/rvfi_trap_rules.sv */
// Purely combinational, the result is valid only in a retirement cycle
// Rules that look back need follow_i, which marks a trapping previous retirement

`timescale 1ns/1ns

module rvfi_trap_rules import rvfi_chk_pkg::*; (
  input  logic       retire_i,
  input  logic       follow_i,
  input  logic       prev_clean_i,
  input  logic       prev_exc_i,
  input  logic       prev_dbg_i,
  input  exc_cause_t prev_cause_i,
  input  dbg_cause_t prev_dbg_cause_i,
  input  logic       rvfi_intr_i,
  input  logic       rvfi_trap_exc_i,
  input  logic       rvfi_trap_dbg_i,
  input  dbg_cause_t rvfi_trap_dbg_cause_i,
  input  dbg_cause_t rvfi_dbg_i,
  input  exc_cause_t rvfi_mcause_i,
  output trap_viol_t trap_viol_o
);

  logic look_back;
  logic look_back_clean;
  logic step_exc;

  // The current retirement follows a trapping one
  assign look_back = retire_i && follow_i;

  // Debug mode or single stepping in the window exempts the interrupt and mcause rules,
  // since mcause is not updated in debug mode
  assign look_back_clean = look_back && prev_clean_i;

  // An exception and a debug trap on the same retirement only occur while stepping
  assign step_exc = retire_i && rvfi_trap_exc_i && rvfi_trap_dbg_i;

  always_comb begin
    trap_viol_o = '0;

    ////////////////////////////////////////////////////////////
    // Trap followed by the interrupt flag
    ////////////////////////////////////////////////////////////

    // The first handler instruction after any trap must carry intr
    trap_viol_o[RULE_TRAP_INTR] = look_back_clean && !rvfi_intr_i;

    ////////////////////////////////////////////////////////////
    // Cause alignment
    ////////////////////////////////////////////////////////////

    // mcause seen by the handler must match the cause the previous retirement reported
    trap_viol_o[RULE_MCAUSE] = look_back_clean && prev_exc_i &&
                               (rvfi_mcause_i != prev_cause_i);

    // Debug entry cause must match the cause the debug trap announced
    // No clean exemption here, because the entry itself lands in debug mode
    trap_viol_o[RULE_DBG_CAUSE] = look_back && prev_dbg_i &&
                                  (rvfi_dbg_i != prev_dbg_cause_i);

    ////////////////////////////////////////////////////////////
    // Single-step encoding
    ////////////////////////////////////////////////////////////

    // Both trap kinds together are only legal with the step cause
    trap_viol_o[RULE_STEP_ENC] = step_exc && (rvfi_trap_dbg_cause_i != DBG_CAUSE_STEP);
  end

endmodule

/* source/rvfi_chk_ctrl.sv */
// Tracks the previous checked retirement while the checker is enabled
// Disabling returns to CHK_OFF, so re-enabling starts without a previous retirement

`timescale 1ns/1ns

module rvfi_chk_ctrl import rvfi_chk_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       ctrl_en_i,
  input  logic       rvfi_valid_i,
  input  logic       rvfi_trap_exc_i,
  input  logic       rvfi_trap_dbg_i,
  input  exc_cause_t rvfi_trap_cause_i,
  input  dbg_cause_t rvfi_trap_dbg_cause_i,
  input  logic       debug_mode_i,
  input  logic       rvfi_dcsr_step_i,
  output logic       retire_o,
  output logic       clear_o,
  output logic       follow_o,
  output logic       prev_clean_o,
  output logic       prev_exc_o,
  output logic       prev_dbg_o,
  output exc_cause_t prev_cause_o,
  output dbg_cause_t prev_dbg_cause_o
);

  chk_state_e state_q;
  chk_state_e state_d;
  logic       quiet;
  logic       clean_q;

  // A cycle is quiet when the core is neither in debug mode nor single stepping
  assign quiet    = !debug_mode_i && !rvfi_dcsr_step_i;
  assign retire_o = rvfi_valid_i && ctrl_en_i;
  assign clear_o  = (state_q == CHK_OFF);
  assign follow_o = (state_q == CHK_FOLLOW);
  // The current cycle counts toward the clean window as well
  assign prev_clean_o = clean_q && quiet;

  always_comb begin
    state_d = state_q;
    if (!ctrl_en_i) begin
      state_d = CHK_OFF;
    end else if (rvfi_valid_i) begin
      // A trapping retirement becomes the previous one that the rules look back on
      state_d = (rvfi_trap_exc_i || rvfi_trap_dbg_i) ? CHK_FOLLOW : CHK_ARMED;
    end else if (state_q == CHK_OFF) begin
      state_d = CHK_ARMED;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CHK_OFF;
      clean_q <= 1'b1;
    end else begin
      state_q <= state_d;
      // The clean window restarts with each retirement and closes on any noisy cycle
      clean_q <= retire_o ? quiet : (clean_q && quiet);
    end
  end

  // Trap record of the last retirement, only read while in CHK_FOLLOW
  always_ff @(posedge clk_i) begin
    if (retire_o) begin
      prev_exc_o       <= rvfi_trap_exc_i;
      prev_dbg_o       <= rvfi_trap_dbg_i;
      prev_cause_o     <= rvfi_trap_cause_i;
      prev_dbg_cause_o <= rvfi_trap_dbg_cause_i;
    end
  end

endmodule

/* source/rvfi_chk_pkg.sv */
// Shared widths, types and constants of the retirement-trace checker
// Rule bits keep the trap rules in the low four bits and the acknowledge rules above them

package rvfi_chk_pkg;

  ////////////////////////////////////////////////////////////
  // Trace field widths
  ////////////////////////////////////////////////////////////

  // Retired instruction address
  typedef logic [31:0] pc_t;
  // Exception cause as found in the low bits of mcause
  typedef logic [5:0]  exc_cause_t;
  // Debug entry cause, zero when there is no debug entry
  typedef logic [2:0]  dbg_cause_t;

  ////////////////////////////////////////////////////////////
  // Rule vectors and counters
  ////////////////////////////////////////////////////////////

  localparam int unsigned NUM_RULES = 6;

  typedef logic [3:0]           trap_viol_t;
  typedef logic [1:0]           ack_viol_t;
  typedef logic [NUM_RULES-1:0] rule_vec_t;
  typedef logic [15:0]          viol_cnt_t;
  // Outstanding debug acknowledges, saturating at 3
  typedef logic [1:0]           ack_cnt_t;

  // Rule indices inside rule_vec_t
  localparam int unsigned RULE_TRAP_INTR = 0;
  localparam int unsigned RULE_MCAUSE    = 1;
  localparam int unsigned RULE_DBG_CAUSE = 2;
  localparam int unsigned RULE_STEP_ENC  = 3;
  localparam int unsigned RULE_IRQ_ACK   = 4;
  localparam int unsigned RULE_DBG_ACK   = 5;

  // Debug cause of a single-step entry
  localparam dbg_cause_t DBG_CAUSE_STEP = 3'd4;

  // Control states
  typedef enum logic [1:0] {
    CHK_OFF,
    CHK_ARMED,
    CHK_FOLLOW
  } chk_state_e;

  ////////////////////////////////////////////////////////////
  // Register port
  ////////////////////////////////////////////////////////////

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  localparam axil_addr_t REG_CTRL     = 4'h0;
  localparam axil_addr_t REG_STATUS   = 4'h4;
  localparam axil_addr_t REG_COUNT    = 4'h8;
  localparam axil_addr_t REG_FIRST_PC = 4'hC;

  localparam int unsigned CTRL_EN_BIT   = 0;
  localparam int unsigned CTRL_MASK_LSB = 8;

  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

endpackage
